// File: rtl/wiener_pixel_pkg.sv
/* pixel word layout shared by the design and its testbench
   input pad byte is ignored, output pad byte is always zero */
`default_nettype none

package wiener_pixel_pkg;

  // one colour sample
  localparam int CH_WIDTH = 8;

  // full bus word, one pixel per clock
  localparam int PIXEL_WIDTH = 32;

  // byte order on the bus, msb first
  typedef struct packed {
    logic [CH_WIDTH-1:0] pad;  // unused on input
    logic [CH_WIDTH-1:0] b;
    logic [CH_WIDTH-1:0] g;
    logic [CH_WIDTH-1:0] r;    // lowest byte
  } rgb_pixel_t;

  // same word taken as a raw bus value or split into channels
  typedef union packed {
    logic [PIXEL_WIDTH-1:0] raw;
    rgb_pixel_t             rgb;
  } pixel_word_u;

endpackage

`default_nettype wire

// File: rtl/wiener_filter_pkg.sv
/* block size and arithmetic widths of the filter; TOTAL_SAMPLES must stay a
   power of two and LOG2_SAMPLES must match it */
`default_nettype none

package wiener_filter_pkg;

  localparam int TOTAL_SAMPLES = 64;  // pixels per block
  localparam int LOG2_SAMPLES  = 6;

  localparam int VAR_WIDTH   = 16;  // variance and noise variance
  localparam int GAIN_FRAC   = 8;   // unity gain is 256
  localparam int GAIN_WIDTH  = 9;
  localparam int COUNT_WIDTH = 32;

  // accumulators sized so a full block never overflows
  localparam int SUM_WIDTH   = wiener_pixel_pkg::CH_WIDTH + LOG2_SAMPLES;
  localparam int SQSUM_WIDTH = 2 * wiener_pixel_pkg::CH_WIDTH + LOG2_SAMPLES;

  // signed (x - mean) * gain with headroom for the mean add
  localparam int PROD_WIDTH = wiener_pixel_pkg::CH_WIDTH + GAIN_WIDTH + 2;

  // 1 input stage, block fill, 1 stats, divider, read and output stages
  localparam int LATENCY = TOTAL_SAMPLES + GAIN_WIDTH + 4;

  typedef logic signed [PROD_WIDTH-1:0] prod_t;

  // latched at start of frame
  typedef struct packed {
    logic [VAR_WIDTH-1:0]   noise_variance;
    logic [COUNT_WIDTH-1:0] blocks_per_frame;
  } wiener_cfg_t;

  // per block, per channel
  typedef struct packed {
    logic [wiener_pixel_pkg::CH_WIDTH-1:0] mean;
    logic [VAR_WIDTH-1:0]                  variance;
  } block_stats_t;

endpackage

`default_nettype wire

// File: rtl/wiener_config_regs.sv
/* start_data is honoured only inside an open frame and up to blocks_per_frame
   times; start_data in the start_of_frame cycle itself is dropped */
`default_nettype none

module wiener_config_regs (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     start_of_frame,
  input  logic                                     end_of_frame,
  input  logic                                     start_data,
  input  logic [wiener_filter_pkg::VAR_WIDTH-1:0]   noise_variance,
  input  logic [wiener_filter_pkg::COUNT_WIDTH-1:0] blocks_per_frame,
  output wiener_filter_pkg::wiener_cfg_t           cfg,
  output logic                                     frame_start,
  output logic                                     block_start
);

  logic                                     frame_open;
  logic [wiener_filter_pkg::COUNT_WIDTH-1:0] blk_cnt;  // blocks admitted this frame
  logic                                     admit;

  assign admit = start_data && !start_of_frame && frame_open &&
                 (blk_cnt < cfg.blocks_per_frame);

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg         <= '0;
      frame_open  <= 1'b0;
      blk_cnt     <= '0;
      frame_start <= 1'b0;
      block_start <= 1'b0;
    end else begin
      frame_start <= start_of_frame;
      block_start <= admit;  // same stage as the data delay in the top
      if (start_of_frame) begin
        cfg.noise_variance   <= noise_variance;
        cfg.blocks_per_frame <= blocks_per_frame;
        frame_open           <= 1'b1;
        blk_cnt              <= '0;
      end else begin
        if (end_of_frame) begin
          frame_open <= 1'b0;
        end
        if (admit) begin
          blk_cnt <= blk_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/block_stats.sv
/* mean and variance over TOTAL_SAMPLES consecutive samples from block_start;
   stats hold only in the stats_valid cycle, the next block overwrites them */
`default_nettype none

module block_stats (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  block_start,
  input  logic                                  sample_valid,
  input  logic [wiener_pixel_pkg::CH_WIDTH-1:0] sample,
  output wiener_filter_pkg::block_stats_t       stats,
  output logic                                  stats_valid
);

  logic [wiener_filter_pkg::LOG2_SAMPLES-1:0] cnt;  // samples taken so far
  logic [wiener_filter_pkg::SUM_WIDTH-1:0]    sum;
  logic [wiener_filter_pkg::SQSUM_WIDTH-1:0]  sq_sum;
  logic [wiener_filter_pkg::VAR_WIDTH-1:0]    sample_sq;
  logic [wiener_filter_pkg::VAR_WIDTH-1:0]    sq_mean;
  logic [wiener_filter_pkg::VAR_WIDTH-1:0]    mean_sq;

  assign sample_sq = {{wiener_pixel_pkg::CH_WIDTH{1'b0}}, sample} *
                     {{wiener_pixel_pkg::CH_WIDTH{1'b0}}, sample};

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt         <= '0;
      stats_valid <= 1'b0;
    end else begin
      // last sample has index all ones and is not a fresh start
      stats_valid <= sample_valid && !block_start && (&cnt);
      if (sample_valid) begin
        cnt <= (block_start ? '0 : cnt) + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample_valid) begin
      sum    <= (block_start ? '0 : sum) +
                {{wiener_filter_pkg::LOG2_SAMPLES{1'b0}}, sample};
      sq_sum <= (block_start ? '0 : sq_sum) +
                {{wiener_filter_pkg::LOG2_SAMPLES{1'b0}}, sample_sq};
    end
  end

  // divide by block size with shifts, never negative
  always_comb begin
    stats.mean     = sum[wiener_filter_pkg::SUM_WIDTH-1:wiener_filter_pkg::LOG2_SAMPLES];
    sq_mean        = sq_sum[wiener_filter_pkg::SQSUM_WIDTH-1:wiener_filter_pkg::LOG2_SAMPLES];
    mean_sq        = {{wiener_pixel_pkg::CH_WIDTH{1'b0}}, stats.mean} *
                     {{wiener_pixel_pkg::CH_WIDTH{1'b0}}, stats.mean};
    stats.variance = sq_mean - mean_sq;
  end

endmodule

`default_nettype wire

// File: rtl/gain_divider.sv
/* gain = floor(excess * 256 / variance), done GAIN_WIDTH+1 cycles after start;
   start must not come while busy, gain holds until the next start */
`default_nettype none

module gain_divider (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   start,
  input  wiener_filter_pkg::block_stats_t        stats,
  input  logic [wiener_filter_pkg::VAR_WIDTH-1:0] noise_variance,
  output logic [wiener_filter_pkg::GAIN_WIDTH-1:0] gain,
  output logic                                   done
);

  logic [wiener_filter_pkg::VAR_WIDTH-1:0]  excess;
  logic [wiener_filter_pkg::VAR_WIDTH-1:0]  divisor;
  logic [wiener_filter_pkg::VAR_WIDTH-1:0]  rem;      // always below divisor
  logic [wiener_filter_pkg::VAR_WIDTH:0]    trial;
  logic [wiener_filter_pkg::VAR_WIDTH:0]    trial_sub;
  logic                                     fits;
  logic [wiener_filter_pkg::GAIN_WIDTH-1:0] num_lo;   // dividend bits not yet shifted in
  logic [wiener_filter_pkg::GAIN_WIDTH-1:0] quo;
  logic [wiener_filter_pkg::GAIN_WIDTH-1:0] step_sr;  // one bit per iteration left
  logic                                     var_zero;

  assign excess = (stats.variance > noise_variance) ? stats.variance - noise_variance : '0;

  assign trial     = {rem, num_lo[wiener_filter_pkg::GAIN_WIDTH-1]};
  assign trial_sub = trial - {1'b0, divisor};
  assign fits      = trial >= {1'b0, divisor};

  assign gain = var_zero ? '0 : quo;  // flat block keeps its pixels

  always_ff @(posedge clk) begin
    if (rst) begin
      step_sr <= '0;
      done    <= 1'b0;
    end else begin
      done <= step_sr[0] & ~step_sr[1];  // last iteration
      if (start) begin
        step_sr <= '1;
      end else begin
        step_sr <= step_sr >> 1;
      end
    end
  end

  // quotient fits GAIN_WIDTH bits since excess <= variance, so the top
  // dividend bits seed the remainder directly
  always_ff @(posedge clk) begin
    if (start) begin
      rem      <= excess >> 1;
      num_lo   <= {excess[0], {wiener_filter_pkg::GAIN_FRAC{1'b0}}};
      divisor  <= stats.variance;
      var_zero <= (stats.variance == '0);
      quo      <= '0;
    end else if (step_sr[0]) begin
      rem    <= fits ? trial_sub[wiener_filter_pkg::VAR_WIDTH-1:0]
                     : trial[wiener_filter_pkg::VAR_WIDTH-1:0];
      num_lo <= num_lo << 1;
      quo    <= {quo[wiener_filter_pkg::GAIN_WIDTH-2:0], fits};
    end
  end

endmodule

`default_nettype wire

// File: rtl/wiener_1_channel.sv
/* one colour channel; blocks need start spacing of at least TOTAL_SAMPLES cycles,
   output starts LATENCY-1 cycles after block_start with no back-pressure */
`default_nettype none

module wiener_1_channel (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     frame_start,
  input  logic                                     block_start,
  input  logic [wiener_pixel_pkg::CH_WIDTH-1:0]     data_in,
  input  logic [wiener_filter_pkg::VAR_WIDTH-1:0]   noise_variance,
  output logic [wiener_pixel_pkg::CH_WIDTH-1:0]     data_out,
  output logic                                     out_valid,
  output logic [wiener_filter_pkg::COUNT_WIDTH-1:0] data_count
);

  wiener_filter_pkg::block_stats_t          stats;
  logic                                     stats_valid;
  logic [wiener_filter_pkg::GAIN_WIDTH-1:0] gain;
  logic                                     gain_done;

  // two banks, bank select is the address msb
  logic [wiener_pixel_pkg::CH_WIDTH-1:0] buf_mem [2*wiener_filter_pkg::TOTAL_SAMPLES];

  logic                                       sample_valid;
  logic                                       wr_active;
  logic                                       wr_bank;    // bank of the block being filled
  logic                                       wr_sel;
  logic [wiener_filter_pkg::LOG2_SAMPLES-1:0] wr_addr;
  logic [wiener_filter_pkg::LOG2_SAMPLES-1:0] wr_idx;
  logic                                       pend_bank;  // measured, waiting for gain
  logic [wiener_pixel_pkg::CH_WIDTH-1:0]      mean_pend;
  logic                                       rd_active;
  logic                                       rd_bank;
  logic [wiener_filter_pkg::LOG2_SAMPLES-1:0] rd_addr;
  logic [wiener_pixel_pkg::CH_WIDTH-1:0]      mean_rd;
  logic [wiener_filter_pkg::GAIN_WIDTH-1:0]   gain_rd;
  logic [wiener_pixel_pkg::CH_WIDTH-1:0]      rd_sample;
  logic [wiener_pixel_pkg::CH_WIDTH-1:0]      pix_out;
  wiener_filter_pkg::prod_t                   x_s;
  wiener_filter_pkg::prod_t                   m_s;
  wiener_filter_pkg::prod_t                   g_s;
  wiener_filter_pkg::prod_t                   adj;

  assign sample_valid = block_start | wr_active;
  assign wr_sel       = block_start ? ~wr_bank : wr_bank;  // bank flips on the start edge
  assign wr_idx       = block_start ? '0 : wr_addr;
  assign rd_sample    = buf_mem[{rd_bank, rd_addr}];

  block_stats stats_inst (
    .clk          (clk),
    .rst          (rst),
    .block_start  (block_start),
    .sample_valid (sample_valid),
    .sample       (data_in),
    .stats        (stats),
    .stats_valid  (stats_valid)
  );

  gain_divider div_inst (
    .clk            (clk),
    .rst            (rst),
    .start          (stats_valid),
    .stats          (stats),
    .noise_variance (noise_variance),
    .gain           (gain),
    .done           (gain_done)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_active  <= 1'b0;
      wr_bank    <= 1'b0;
      wr_addr    <= '0;
      pend_bank  <= 1'b0;
      rd_active  <= 1'b0;
      rd_bank    <= 1'b0;
      rd_addr    <= '0;
      out_valid  <= 1'b0;
      data_count <= '0;
    end else begin
      if (block_start) begin
        wr_bank <= ~wr_bank;
      end
      if (sample_valid) begin
        wr_addr   <= wr_idx + 1'b1;
        wr_active <= ~&wr_idx;  // stop after the last address
      end
      if (stats_valid) begin
        pend_bank <= wr_bank;
      end
      // a new gain may land on the last read of the previous block
      if (gain_done) begin
        rd_active <= 1'b1;
        rd_bank   <= pend_bank;
        rd_addr   <= '0;
      end else if (rd_active) begin
        rd_addr   <= rd_addr + 1'b1;
        rd_active <= ~&rd_addr;
      end
      out_valid <= rd_active;
      if (frame_start) begin
        data_count <= {{(wiener_filter_pkg::COUNT_WIDTH-1){1'b0}}, out_valid};
      end else if (out_valid) begin
        data_count <= data_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample_valid) begin
      buf_mem[{wr_sel, wr_idx}] <= data_in;
    end
    if (stats_valid) begin
      mean_pend <= stats.mean;
    end
    if (gain_done) begin
      mean_rd <= mean_pend;
      gain_rd <= gain;
    end
    data_out <= pix_out;
  end

  // mean + ((x - mean) * gain >>> 8), clamped to a byte
  always_comb begin
    x_s = wiener_filter_pkg::prod_t'(rd_sample);
    m_s = wiener_filter_pkg::prod_t'(mean_rd);
    g_s = wiener_filter_pkg::prod_t'(gain_rd);
    adj = (((x_s - m_s) * g_s) >>> wiener_filter_pkg::GAIN_FRAC) + m_s;
    if (adj[wiener_filter_pkg::PROD_WIDTH-1]) begin
      pix_out = '0;
    end else if (|adj[wiener_filter_pkg::PROD_WIDTH-2:wiener_pixel_pkg::CH_WIDTH]) begin
      pix_out = '1;  // saturate high
    end else begin
      pix_out = adj[wiener_pixel_pkg::CH_WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire

// File: rtl/wiener_3_channels.sv
/* three identical channel pipelines in lock step; data_count reads all ones
   whenever the channel counters disagree */
`default_nettype none

module wiener_3_channels (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     frame_start,
  input  logic                                     block_start,
  input  wiener_pixel_pkg::pixel_word_u            data_in,
  input  logic [wiener_filter_pkg::VAR_WIDTH-1:0]   noise_variance,
  output wiener_pixel_pkg::pixel_word_u            data_out,
  output logic                                     out_valid,
  output logic [wiener_filter_pkg::COUNT_WIDTH-1:0] data_count
);

  logic [wiener_pixel_pkg::CH_WIDTH-1:0]     red_out;
  logic [wiener_pixel_pkg::CH_WIDTH-1:0]     green_out;
  logic [wiener_pixel_pkg::CH_WIDTH-1:0]     blue_out;
  logic [wiener_filter_pkg::COUNT_WIDTH-1:0] red_count;
  logic [wiener_filter_pkg::COUNT_WIDTH-1:0] green_count;
  logic [wiener_filter_pkg::COUNT_WIDTH-1:0] blue_count;

  // red strobe stands for all three
  wiener_1_channel red_ch (
    .clk (clk), .rst (rst), .frame_start (frame_start), .block_start (block_start),
    .data_in (data_in.rgb.r), .noise_variance (noise_variance),
    .data_out (red_out), .out_valid (out_valid), .data_count (red_count)
  );

  wiener_1_channel green_ch (
    .clk (clk), .rst (rst), .frame_start (frame_start), .block_start (block_start),
    .data_in (data_in.rgb.g), .noise_variance (noise_variance),
    .data_out (green_out), .out_valid (), .data_count (green_count)
  );

  wiener_1_channel blue_ch (
    .clk (clk), .rst (rst), .frame_start (frame_start), .block_start (block_start),
    .data_in (data_in.rgb.b), .noise_variance (noise_variance),
    .data_out (blue_out), .out_valid (), .data_count (blue_count)
  );

  always_comb begin
    data_out.rgb.pad = '0;
    data_out.rgb.b   = blue_out;
    data_out.rgb.g   = green_out;
    data_out.rgb.r   = red_out;
  end

  always_comb begin
    if (red_count == green_count && red_count == blue_count) begin
      data_count = red_count;
    end else begin
      data_count = '1;  // channels out of step
    end
  end

endmodule

`default_nettype wire

// File: rtl/wiener_filter_top.sv
/* first pixel of an admitted block leaves LATENCY cycles after its start_data;
   inputs are sampled every cycle, no flow control */
`default_nettype none

module wiener_filter_top (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     start_of_frame,
  input  logic                                     end_of_frame,
  input  logic                                     start_data,
  input  logic [wiener_pixel_pkg::PIXEL_WIDTH-1:0]  data_in,
  input  logic [wiener_filter_pkg::VAR_WIDTH-1:0]   noise_variance,
  input  logic [wiener_filter_pkg::COUNT_WIDTH-1:0] blocks_per_frame,
  output logic [wiener_pixel_pkg::PIXEL_WIDTH-1:0]  data_out,
  output logic                                     out_valid,
  output logic [wiener_filter_pkg::COUNT_WIDTH-1:0] data_count
);

  wiener_filter_pkg::wiener_cfg_t cfg;
  logic                           frame_start;
  logic                           block_start;
  wiener_pixel_pkg::pixel_word_u  data_d;   // aligned with block_start
  wiener_pixel_pkg::pixel_word_u  data_o;

  always_ff @(posedge clk) begin
    data_d.raw <= data_in;
  end

  wiener_config_regs cfg_regs_inst (
    .clk              (clk),
    .rst              (rst),
    .start_of_frame   (start_of_frame),
    .end_of_frame     (end_of_frame),
    .start_data       (start_data),
    .noise_variance   (noise_variance),
    .blocks_per_frame (blocks_per_frame),
    .cfg              (cfg),
    .frame_start      (frame_start),
    .block_start      (block_start)
  );

  wiener_3_channels channels_inst (
    .clk            (clk),
    .rst            (rst),
    .frame_start    (frame_start),
    .block_start    (block_start),
    .data_in        (data_d),
    .noise_variance (cfg.noise_variance),
    .data_out       (data_o),
    .out_valid      (out_valid),
    .data_count     (data_count)
  );

  assign data_out = data_o.raw;

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
/* free running clock for the testbench, period 10, starts low */
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // half period
  end

endmodule

`default_nettype wire

// File: verification/wiener_checker.sv
/* compares every out_valid word and its arrival cycle with a queue that the
   sequencer fills before each admitted block is sent */
`default_nettype none

module wiener_checker (
  input logic                                     clk,
  input logic                                     rst,
  input logic                                     out_valid,
  input logic [wiener_pixel_pkg::PIXEL_WIDTH-1:0]  data_out,
  input logic [wiener_filter_pkg::COUNT_WIDTH-1:0] data_count
);

  logic [wiener_pixel_pkg::PIXEL_WIDTH-1:0] exp_word_q [$];
  int                                       exp_cycle_q [$];
  int                                       cycle = 0;   // rising edges seen so far
  int                                       errors = 0;
  int                                       checked = 0;

  task automatic expect_pixel(input logic [31:0] word, input int at_cycle);
    exp_word_q.push_back(word);
    exp_cycle_q.push_back(at_cycle);
  endtask

  function automatic int pending();
    return exp_word_q.size();
  endfunction

  // anything still queued here never reached the output
  task automatic close_test();
    if (exp_word_q.size() != 0) begin
      $display("%0d expected pixels never came out by time %0t", exp_word_q.size(), $time);
      errors++;
      exp_word_q.delete();
      exp_cycle_q.delete();
    end
  endtask

  task automatic check_count(input int expected);
    if (data_count !== 32'(expected)) begin
      $display("ERROR %0t: data_count %0d, expected %0d", $time, data_count, expected);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    logic [31:0] want;
    int          want_cycle;
    cycle = cycle + 1;
    if (!rst && out_valid) begin
      if (exp_word_q.size() == 0) begin
        $display("output pixel %h at time %0t came while no pixel was expected",
                 data_out, $time);
        errors++;
      end else begin
        want       = exp_word_q.pop_front();
        want_cycle = exp_cycle_q.pop_front();
        checked++;
        if (data_out !== want) begin
          $display("ERROR %0t: pixel got %h, expected %h", $time, data_out, want);
          errors++;
        end
        if (cycle != want_cycle) begin  // latency or gap in the stream
          $display("ERROR %0t: pixel in cycle %0d, expected cycle %0d",
                   $time, cycle, want_cycle);
          errors++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_wiener_filter_top.sv
/* self-checking testbench, pixels come from an LFSR; each test opens its own
   frame and drains all output before the next one starts */
`default_nettype none

module tb_wiener_filter_top;

  logic        clk;
  logic        rst;
  logic        start_of_frame;
  logic        end_of_frame;
  logic        start_data;
  logic [31:0] data_in;
  logic [15:0] noise_variance;
  logic [31:0] blocks_per_frame;
  logic [31:0] data_out;
  logic        out_valid;
  logic [31:0] data_count;

  logic [31:0] lfsr_state;
  int          cur_noise;       // noise the DUT latched for this frame
  int          tests_run;
  int          failed_tests;
  int          errors_before;

  tb_clock_gen clk_gen_inst (.clk (clk));

  wiener_filter_top wiener_filter_top_inst (
    .clk              (clk),
    .rst              (rst),
    .start_of_frame   (start_of_frame),
    .end_of_frame     (end_of_frame),
    .start_data       (start_data),
    .data_in          (data_in),
    .noise_variance   (noise_variance),
    .blocks_per_frame (blocks_per_frame),
    .data_out         (data_out),
    .out_valid        (out_valid),
    .data_count       (data_count)
  );

  wiener_checker checker_inst (
    .clk        (clk),
    .rst        (rst),
    .out_valid  (out_valid),
    .data_out   (data_out),
    .data_count (data_count)
  );

  // taps 32 22 2 1 with the new bit entering at bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic int channel_of(input logic [31:0] word, input int c);
    wiener_pixel_pkg::pixel_word_u w;
    w.raw = word;
    case (c)
      0:       return int'(w.rgb.r);
      1:       return int'(w.rgb.g);
      default: return int'(w.rgb.b);
    endcase
  endfunction

  // expected output of one sample from its block sums
  function automatic logic [7:0] filter_sample(input int x, input int sum,
                                               input int sq_sum, input int noise);
    int mean;
    int var_b;
    int excess;
    int gain;
    int y;
    mean   = sum >> wiener_filter_pkg::LOG2_SAMPLES;
    var_b  = (sq_sum >> wiener_filter_pkg::LOG2_SAMPLES) - mean * mean;
    excess = (var_b > noise) ? var_b - noise : 0;
    gain   = (var_b == 0) ? 0 : (excess << wiener_filter_pkg::GAIN_FRAC) / var_b;
    y      = mean + (((x - mean) * gain) >>> wiener_filter_pkg::GAIN_FRAC);
    if (y < 0) begin
      y = 0;
    end else if (y > 255) begin
      y = 255;
    end
    return y[7:0];
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic start_frame(input logic [15:0] noise, input int blocks);
    start_of_frame   = 1'b1;
    noise_variance   = noise;
    blocks_per_frame = 32'(blocks);
    cur_noise        = int'(noise);
    next_cycle();
    start_of_frame   = 1'b0;
    noise_variance   = ~noise;  // latched values must hold inside the frame
    blocks_per_frame = '0;
  endtask

  task automatic end_frame();
    end_of_frame = 1'b1;
    next_cycle();
    end_of_frame = 1'b0;
  endtask

  // flat repeats one word for the whole block
  task automatic send_block(input logic flat, input logic admitted);
    logic [31:0] pix [wiener_filter_pkg::TOTAL_SAMPLES];
    int          sum [3];
    int          sq_sum [3];
    int          first_cycle;
    int          i;
    int          c;
    int          x;
    logic [31:0] word;
    wiener_pixel_pkg::pixel_word_u want;
    for (c = 0; c < 3; c++) begin
      sum[c]    = 0;
      sq_sum[c] = 0;
    end
    word = '0;
    for (i = 0; i < wiener_filter_pkg::TOTAL_SAMPLES; i++) begin
      if (i == 0 || !flat) begin
        take_bits(32, word);
      end
      pix[i] = word;
      for (c = 0; c < 3; c++) begin
        x         = channel_of(word, c);
        sum[c]    = sum[c] + x;
        sq_sum[c] = sq_sum[c] + x * x;
      end
    end
    if (admitted) begin
      // start_data is sampled on the next edge
      first_cycle = checker_inst.cycle + 1 + wiener_filter_pkg::LATENCY;
      for (i = 0; i < wiener_filter_pkg::TOTAL_SAMPLES; i++) begin
        want.rgb.pad = '0;
        want.rgb.r   = filter_sample(channel_of(pix[i], 0), sum[0], sq_sum[0], cur_noise);
        want.rgb.g   = filter_sample(channel_of(pix[i], 1), sum[1], sq_sum[1], cur_noise);
        want.rgb.b   = filter_sample(channel_of(pix[i], 2), sum[2], sq_sum[2], cur_noise);
        checker_inst.expect_pixel(want.raw, first_cycle + i);
      end
    end
    for (i = 0; i < wiener_filter_pkg::TOTAL_SAMPLES; i++) begin
      start_data = (i == 0);
      data_in    = pix[i];
      next_cycle();
    end
    start_data = 1'b0;
  endtask

  task automatic begin_test();
    errors_before = checker_inst.errors;
  endtask

  // drain and then wait out a quiet window long enough for a stray block to show up
  task automatic finish_test(input int num, input string name, input int admitted);
    int waited;
    int errs;
    waited = 0;
    while (checker_inst.pending() > 0 && waited < 4 * wiener_filter_pkg::LATENCY) begin
      next_cycle();
      waited++;
    end
    idle(wiener_filter_pkg::TOTAL_SAMPLES + wiener_filter_pkg::LATENCY);
    checker_inst.close_test();
    checker_inst.check_count(admitted * wiener_filter_pkg::TOTAL_SAMPLES);
    errs = checker_inst.errors - errors_before;
    tests_run++;
    if (errs != 0) begin
      failed_tests++;
    end
    $display("test %0d %s: %s with %0d errors", num, name, (errs == 0) ? "ok" : "FAILED", errs);
  endtask

  initial begin
    rst              = 1'b1;
    start_of_frame   = 1'b0;
    end_of_frame     = 1'b0;
    start_data       = 1'b0;
    data_in          = '0;
    noise_variance   = '0;
    blocks_per_frame = '0;
    lfsr_state       = 32'he2ca;
    cur_noise        = 0;
    tests_run        = 0;
    failed_tests     = 0;
    errors_before    = 0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    next_cycle();

    begin_test();
    start_frame(16'd40, 2);
    send_block(1'b1, 1'b1);
    idle(3);
    send_block(1'b1, 1'b1);
    end_frame();
    finish_test(1, "flat blocks", 2);

    begin_test();
    start_frame(16'd0, 2);  // unity gain
    send_block(1'b0, 1'b1);
    idle(5);
    send_block(1'b0, 1'b1);
    end_frame();
    finish_test(2, "zero noise", 2);

    begin_test();
    start_frame(16'd2000, 3);
    send_block(1'b0, 1'b1);
    idle(2);
    send_block(1'b0, 1'b1);
    idle(7);
    send_block(1'b0, 1'b1);
    end_frame();
    finish_test(3, "moderate noise", 3);

    begin_test();
    start_frame(16'hffff, 2);  // gain 0 so outputs collapse to the mean
    send_block(1'b0, 1'b1);
    idle(4);
    send_block(1'b0, 1'b1);
    end_frame();
    finish_test(4, "huge noise", 2);

    begin_test();
    send_block(1'b0, 1'b0);  // frame still closed
    start_frame(16'd500, 2);
    send_block(1'b0, 1'b1);
    send_block(1'b0, 1'b1);
    send_block(1'b0, 1'b0);  // over blocks_per_frame
    end_frame();
    send_block(1'b0, 1'b0);
    finish_test(5, "frame control", 2);

    begin_test();
    start_frame(16'd1000, 4);
    repeat (4) send_block(1'b0, 1'b1);
    end_frame();
    finish_test(6, "back to back", 4);

    $display("tests run %0d, failed %0d, pixels checked %0d, errors %0d",
             tests_run, failed_tests, checker_inst.checked, checker_inst.errors);
    if (failed_tests == 0 && checker_inst.errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // 18 blocks over 6 tests plus a drain and a quiet window per test
  initial begin
    int run_cycles;
    run_cycles = 18 * (wiener_filter_pkg::TOTAL_SAMPLES + wiener_filter_pkg::LATENCY) +
                 6 * (wiener_filter_pkg::TOTAL_SAMPLES + wiener_filter_pkg::LATENCY + 8) + 100;
    #(run_cycles * 10);
    $display("watchdog expired after %0d cycles, the run did not finish", run_cycles);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: wiener_filter_top.f
rtl/wiener_pixel_pkg.sv
rtl/wiener_filter_pkg.sv
rtl/wiener_config_regs.sv
rtl/block_stats.sv
rtl/gain_divider.sv
rtl/wiener_1_channel.sv
rtl/wiener_3_channels.sv
rtl/wiener_filter_top.sv
verification/tb_clock_gen.sv
verification/wiener_checker.sv
verification/tb_wiener_filter_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_wiener_filter_top
FILELIST  ?= wiener_filter_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove $(BUILD_DIR)"
	@echo "make help   show this list"

# the run passes only if the pass line appears in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
